//--- include/afu_cfg.svh
`ifndef AFU_CFG_SVH
`define AFU_CFG_SVH

// Host bus widths.
`define AFU_ADDR_W 32
`define AFU_DATA_W 32

// Top tag bit is the requester id, low bits are the local tag.
`define AFU_TAG_W 4

// Job limits.
`define AFU_MAX_LEN 64
`define AFU_MAX_OUTSTANDING 4
`define AFU_ERR_W 2

// MMIO register byte offsets.
`define AFU_REG_CTRL 32'h00
`define AFU_REG_WED 32'h04
`define AFU_REG_STATUS 32'h08
`define AFU_REG_RESULT 32'h0C
`define AFU_REG_ERR 32'h10

`endif

//--- verilog/afu_pkg.sv
package afu_pkg;

  // Job sequencing states, as seen in STATUS.
  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    FETCH = 3'd1,
    RUN   = 3'd2,
    DONE  = 3'd3,
    ERROR = 3'd4
  } job_state_e;

  // Requester id carried in the top tag bit.
  typedef enum logic {
    REQ_WED = 1'b0,
    REQ_SUM = 1'b1
  } requester_e;

  // Bit positions in the ERR register.
  typedef enum int {
    ERR_LEN   = 0,
    ERR_ALIGN = 1
  } err_bit_e;

endpackage

//--- verilog/mmio_regs.sv
`include "afu_cfg.svh"

module mmio_regs (
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`AFU_ADDR_W-1:0] paddr,
  input  logic [`AFU_DATA_W-1:0] pwdata,
  output logic [`AFU_DATA_W-1:0] prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic                   start,
  output logic                   abort,
  output logic [`AFU_ADDR_W-1:0] wed_addr,
  input  afu_pkg::job_state_e    state,
  input  logic [`AFU_DATA_W-1:0] result,
  input  logic [`AFU_ERR_W-1:0]  err
);

  localparam int DW = `AFU_DATA_W;

  logic access;
  logic wr;
  logic hit_ctrl;
  logic hit_wed;
  logic hit_status;
  logic hit_result;
  logic hit_err;

  assign access     = psel & penable;
  assign wr         = access & pwrite;
  assign hit_ctrl   = (paddr == `AFU_REG_CTRL);
  assign hit_wed    = (paddr == `AFU_REG_WED);
  assign hit_status = (paddr == `AFU_REG_STATUS);
  assign hit_result = (paddr == `AFU_REG_RESULT);
  assign hit_err    = (paddr == `AFU_REG_ERR);

  // Zero wait states.
  assign pready  = access;
  assign pslverr = access & ~(hit_ctrl | hit_wed | hit_status | hit_result | hit_err);

  // CTRL bits are write-only strobes.
  always_ff @(posedge clock) begin
    if (rst) begin
      start <= 1'b0;
      abort <= 1'b0;
    end else begin
      start <= wr & hit_ctrl & pwdata[0];
      abort <= wr & hit_ctrl & pwdata[1];
    end
  end

  always_ff @(posedge clock) begin
    if (wr && hit_wed) begin
      wed_addr <= pwdata;
    end
  end

  // Status registers are live views of the job controller.
  always_comb begin
    prdata = '0;
    if (hit_wed) begin
      prdata = DW'(wed_addr);
    end else if (hit_status) begin
      prdata = DW'(state);
    end else if (hit_result) begin
      prdata = result;
    end else if (hit_err) begin
      prdata = DW'(err);
    end
  end

  // Access phase only ever follows a setup phase.
  penable_needs_psel: assert property (
    @(posedge clock) disable iff (rst) $rose(penable) |-> psel
  );

endmodule

//--- verilog/job_control.sv
`include "afu_cfg.svh"

module job_control (
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   start,
  input  logic                   abort,
  input  logic [`AFU_ADDR_W-1:0] wed_addr,
  output logic                   wed_start,
  input  logic                   wed_done,
  input  logic [`AFU_ADDR_W-1:0] src_addr,
  input  logic [`AFU_DATA_W-1:0] len,
  output logic                   sum_start,
  input  logic                   sum_done,
  input  logic [`AFU_DATA_W-1:0] sum,
  output afu_pkg::job_state_e    state,
  output logic [`AFU_DATA_W-1:0] result,
  output logic [`AFU_ERR_W-1:0]  err
);

  logic [`AFU_ERR_W-1:0] chk_err;

  // Descriptor checks, sampled when the fetch completes.
  always_comb begin
    chk_err = '0;
    chk_err[afu_pkg::ERR_LEN]   = (len > `AFU_MAX_LEN);
    chk_err[afu_pkg::ERR_ALIGN] = (wed_addr[1:0] != 2'b00) || (src_addr[1:0] != 2'b00);
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      state     <= afu_pkg::IDLE;
      wed_start <= 1'b0;
      sum_start <= 1'b0;
      result    <= '0;
      err       <= '0;
    end else begin
      wed_start <= 1'b0;
      sum_start <= 1'b0;
      if (abort) begin
        state <= afu_pkg::IDLE;
      end else begin
        case (state)
          afu_pkg::FETCH: begin
            if (wed_done) begin
              if (chk_err != '0) begin
                err   <= chk_err;
                state <= afu_pkg::ERROR;
              end else if (len == '0) begin
                state <= afu_pkg::DONE;
              end else begin
                sum_start <= 1'b1;
                state     <= afu_pkg::RUN;
              end
            end
          end
          afu_pkg::RUN: begin
            if (sum_done) begin
              result <= sum;
              state  <= afu_pkg::DONE;
            end
          end
          // Idle, done and error all accept a new job.
          default: begin
            if (start) begin
              result    <= '0;
              err       <= '0;
              wed_start <= 1'b1;
              state     <= afu_pkg::FETCH;
            end
          end
        endcase
      end
    end
  end

  // The engine only finishes a job that is running.
  sum_done_in_run: assert property (
    @(posedge clock) disable iff (rst) sum_done |-> state == afu_pkg::RUN
  );

endmodule

//--- verilog/wed_fetch.sv
`include "afu_cfg.svh"

module wed_fetch (
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   wed_start,
  input  logic                   abort,
  input  logic [`AFU_ADDR_W-1:0] wed_addr,
  output logic                   req_valid,
  output logic [`AFU_ADDR_W-1:0] req_addr,
  output logic [`AFU_TAG_W-2:0]  req_tag,
  input  logic                   grant,
  input  logic                   rsp_valid,
  input  logic [`AFU_TAG_W-2:0]  rsp_tag,
  input  logic [`AFU_DATA_W-1:0] rsp_data,
  output logic                   wed_done,
  output logic [`AFU_ADDR_W-1:0] src_addr,
  output logic [`AFU_DATA_W-1:0] len
);

  localparam int AW = `AFU_ADDR_W;
  localparam int LT = `AFU_TAG_W - 1;

  logic       busy;
  logic [1:0] issued;
  logic       word;
  logic       idx;
  logic       take;
  logic [1:0] pend;
  logic [1:0] pend_next;
  logic [1:0] stale;
  logic [1:0] got;
  logic [1:0] got_next;

  // Word 0 is the source address, word 1 the length.
  assign word      = issued[0];
  assign req_valid = busy & ~issued[1] & ~pend[word];
  assign req_addr  = wed_addr + (AW'(word) << 2);
  assign req_tag   = LT'(word);

  // Responses to an aborted fetch only free their tag.
  assign idx  = rsp_tag[0];
  assign take = rsp_valid & busy & ~stale[idx];

  always_comb begin
    pend_next = pend;
    got_next  = got;
    if (rsp_valid) begin
      pend_next[idx] = 1'b0;
    end
    if (req_valid && grant) begin
      pend_next[word] = 1'b1;
    end
    if (take) begin
      got_next[idx] = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      busy     <= 1'b0;
      issued   <= '0;
      pend     <= '0;
      stale    <= '0;
      got      <= '0;
      wed_done <= 1'b0;
    end else begin
      wed_done <= 1'b0;
      pend     <= pend_next;
      stale    <= abort ? pend_next : (stale & pend_next);
      if (abort) begin
        busy <= 1'b0;
      end else if (wed_start) begin
        busy   <= 1'b1;
        issued <= '0;
        got    <= '0;
      end else if (busy) begin
        got <= got_next;
        if (req_valid && grant) begin
          issued <= issued + 2'd1;
        end
        if (&got_next) begin
          busy     <= 1'b0;
          wed_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (take && !idx) begin
      src_addr <= AW'(rsp_data);
    end
    if (take && idx) begin
      len <= rsp_data;
    end
  end

endmodule

//--- verilog/sum_engine.sv
`include "afu_cfg.svh"

module sum_engine (
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   sum_start,
  input  logic                   abort,
  input  logic [`AFU_ADDR_W-1:0] src_addr,
  input  logic [`AFU_DATA_W-1:0] len,
  output logic                   req_valid,
  output logic [`AFU_ADDR_W-1:0] req_addr,
  output logic [`AFU_TAG_W-2:0]  req_tag,
  input  logic                   grant,
  input  logic                   rsp_valid,
  input  logic [`AFU_TAG_W-2:0]  rsp_tag,
  input  logic [`AFU_DATA_W-1:0] rsp_data,
  output logic                   sum_done,
  output logic [`AFU_DATA_W-1:0] sum
);

  localparam int AW = `AFU_ADDR_W;
  localparam int LT = `AFU_TAG_W - 1;
  localparam int NT = `AFU_MAX_OUTSTANDING;
  localparam int IW = $clog2(NT);
  localparam int LW = $clog2(`AFU_MAX_LEN) + 1;

  logic          active;
  logic [AW-1:0] base;
  logic [LW-1:0] total;
  logic [LW-1:0] issued;
  logic [LW-1:0] rcvd;
  logic [NT-1:0] busy;
  logic [NT-1:0] busy_next;
  logic [NT-1:0] stale;
  logic [IW-1:0] slot;
  logic [IW-1:0] rsp_slot;
  logic          take;

  // Word n always uses slot n mod NT, so the request stays put while it waits.
  assign slot      = issued[IW-1:0];
  assign req_valid = active & (issued != total) & ~busy[slot];
  assign req_addr  = base + (AW'(issued) << 2);
  assign req_tag   = LT'(slot);

  assign rsp_slot = rsp_tag[IW-1:0];
  assign take     = rsp_valid & active & ~stale[rsp_slot];

  always_comb begin
    busy_next = busy;
    if (rsp_valid) begin
      busy_next[rsp_slot] = 1'b0;
    end
    if (req_valid && grant) begin
      busy_next[slot] = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      active   <= 1'b0;
      issued   <= '0;
      rcvd     <= '0;
      busy     <= '0;
      stale    <= '0;
      sum_done <= 1'b0;
    end else begin
      sum_done <= 1'b0;
      busy     <= busy_next;
      // Reads still in flight at abort drain without touching the sum.
      stale    <= abort ? busy_next : (stale & busy_next);
      if (abort) begin
        active <= 1'b0;
      end else if (sum_start) begin
        active <= 1'b1;
        issued <= '0;
        rcvd   <= '0;
      end else if (active) begin
        if (req_valid && grant) begin
          issued <= issued + 1'b1;
        end
        if (take) begin
          rcvd <= rcvd + 1'b1;
          if (rcvd + 1'b1 == total) begin
            active   <= 1'b0;
            sum_done <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (sum_start) begin
      base  <= src_addr;
      total <= len[LW-1:0];
      sum   <= '0;
    end else if (take) begin
      sum <= sum + rsp_data;
    end
  end

  rsp_tag_busy: assert property (
    @(posedge clock) disable iff (rst) rsp_valid |-> busy[rsp_slot]
  );

endmodule

//--- verilog/cmd_arbiter.sv
`include "afu_cfg.svh"

module cmd_arbiter (
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   wed_valid,
  input  logic [`AFU_ADDR_W-1:0] wed_addr,
  input  logic [`AFU_TAG_W-2:0]  wed_tag,
  output logic                   wed_grant,
  input  logic                   sum_valid,
  input  logic [`AFU_ADDR_W-1:0] sum_addr,
  input  logic [`AFU_TAG_W-2:0]  sum_tag,
  output logic                   sum_grant,
  output logic                   cmd_valid,
  output logic [`AFU_ADDR_W-1:0] cmd_addr,
  output logic [`AFU_TAG_W-1:0]  cmd_tag,
  input  logic                   cmd_ready,
  input  logic                   rsp_valid,
  input  logic [`AFU_TAG_W-1:0]  rsp_tag,
  input  logic [`AFU_DATA_W-1:0] rsp_data,
  output logic                   wed_rsp_valid,
  output logic                   sum_rsp_valid,
  output logic [`AFU_TAG_W-2:0]  rsp_local_tag,
  output logic [`AFU_DATA_W-1:0] rsp_word
);

  logic last_sum;
  logic hold;
  logic hold_sum;
  logic sel_sum;

  // A stalled command keeps its requester until accepted.
  always_comb begin
    if (hold) begin
      sel_sum = hold_sum;
    end else if (wed_valid && sum_valid) begin
      sel_sum = ~last_sum;
    end else begin
      sel_sum = sum_valid;
    end
  end

  assign cmd_valid = sel_sum ? sum_valid : wed_valid;
  assign cmd_addr  = sel_sum ? sum_addr : wed_addr;
  assign cmd_tag   = sel_sum ? {afu_pkg::REQ_SUM, sum_tag} : {afu_pkg::REQ_WED, wed_tag};
  assign wed_grant = cmd_valid & cmd_ready & ~sel_sum;
  assign sum_grant = cmd_valid & cmd_ready & sel_sum;

  always_ff @(posedge clock) begin
    if (rst) begin
      last_sum <= 1'b0;
      hold     <= 1'b0;
      hold_sum <= 1'b0;
    end else begin
      hold     <= cmd_valid & ~cmd_ready;
      hold_sum <= sel_sum;
      if (cmd_valid && cmd_ready) begin
        last_sum <= sel_sum;
      end
    end
  end

  // Route by requester id.
  assign wed_rsp_valid = rsp_valid & (rsp_tag[`AFU_TAG_W-1] == afu_pkg::REQ_WED);
  assign sum_rsp_valid = rsp_valid & (rsp_tag[`AFU_TAG_W-1] == afu_pkg::REQ_SUM);
  assign rsp_local_tag = rsp_tag[`AFU_TAG_W-2:0];
  assign rsp_word      = rsp_data;

  // A waiting command keeps its address and tag unless an abort withdraws it.
  cmd_stable_while_stalled: assert property (
    @(posedge clock) disable iff (rst)
    cmd_valid && !cmd_ready |=> !cmd_valid || ($stable(cmd_addr) && $stable(cmd_tag))
  );

endmodule

//--- verilog/afu_top.sv
`include "afu_cfg.svh"

module afu_top (
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`AFU_ADDR_W-1:0] paddr,
  input  logic [`AFU_DATA_W-1:0] pwdata,
  output logic [`AFU_DATA_W-1:0] prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic                   cmd_valid,
  input  logic                   cmd_ready,
  output logic [`AFU_ADDR_W-1:0] cmd_addr,
  output logic [`AFU_TAG_W-1:0]  cmd_tag,
  input  logic                   rsp_valid,
  input  logic [`AFU_TAG_W-1:0]  rsp_tag,
  input  logic [`AFU_DATA_W-1:0] rsp_data
);

  logic                   start;
  logic                   abort;
  logic [`AFU_ADDR_W-1:0] wed_addr;
  afu_pkg::job_state_e    state;
  logic [`AFU_DATA_W-1:0] result;
  logic [`AFU_ERR_W-1:0]  err;
  logic                   wed_start;
  logic                   wed_done;
  logic [`AFU_ADDR_W-1:0] src_addr;
  logic [`AFU_DATA_W-1:0] len;
  logic                   sum_start;
  logic                   sum_done;
  logic [`AFU_DATA_W-1:0] sum;
  logic                   wed_req_valid;
  logic [`AFU_ADDR_W-1:0] wed_req_addr;
  logic [`AFU_TAG_W-2:0]  wed_req_tag;
  logic                   wed_grant;
  logic                   sum_req_valid;
  logic [`AFU_ADDR_W-1:0] sum_req_addr;
  logic [`AFU_TAG_W-2:0]  sum_req_tag;
  logic                   sum_grant;
  logic                   wed_rsp_valid;
  logic                   sum_rsp_valid;
  logic [`AFU_TAG_W-2:0]  rsp_local_tag;
  logic [`AFU_DATA_W-1:0] rsp_word;

  // Host register window.
  mmio_regs mmio_regs_inst (
    .clock   (clock),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .start   (start),
    .abort   (abort),
    .wed_addr(wed_addr),
    .state   (state),
    .result  (result),
    .err     (err)
  );

  job_control job_control_inst (
    .clock    (clock),
    .rst      (rst),
    .start    (start),
    .abort    (abort),
    .wed_addr (wed_addr),
    .wed_start(wed_start),
    .wed_done (wed_done),
    .src_addr (src_addr),
    .len      (len),
    .sum_start(sum_start),
    .sum_done (sum_done),
    .sum      (sum),
    .state    (state),
    .result   (result),
    .err      (err)
  );

  // Descriptor fetch.
  wed_fetch wed_fetch_inst (
    .clock    (clock),
    .rst      (rst),
    .wed_start(wed_start),
    .abort    (abort),
    .wed_addr (wed_addr),
    .req_valid(wed_req_valid),
    .req_addr (wed_req_addr),
    .req_tag  (wed_req_tag),
    .grant    (wed_grant),
    .rsp_valid(wed_rsp_valid),
    .rsp_tag  (rsp_local_tag),
    .rsp_data (rsp_word),
    .wed_done (wed_done),
    .src_addr (src_addr),
    .len      (len)
  );

  // Compute engine.
  sum_engine sum_engine_inst (
    .clock    (clock),
    .rst      (rst),
    .sum_start(sum_start),
    .abort    (abort),
    .src_addr (src_addr),
    .len      (len),
    .req_valid(sum_req_valid),
    .req_addr (sum_req_addr),
    .req_tag  (sum_req_tag),
    .grant    (sum_grant),
    .rsp_valid(sum_rsp_valid),
    .rsp_tag  (rsp_local_tag),
    .rsp_data (rsp_word),
    .sum_done (sum_done),
    .sum      (sum)
  );

  // Shared host command bus.
  cmd_arbiter cmd_arbiter_inst (
    .clock        (clock),
    .rst          (rst),
    .wed_valid    (wed_req_valid),
    .wed_addr     (wed_req_addr),
    .wed_tag      (wed_req_tag),
    .wed_grant    (wed_grant),
    .sum_valid    (sum_req_valid),
    .sum_addr     (sum_req_addr),
    .sum_tag      (sum_req_tag),
    .sum_grant    (sum_grant),
    .cmd_valid    (cmd_valid),
    .cmd_addr     (cmd_addr),
    .cmd_tag      (cmd_tag),
    .cmd_ready    (cmd_ready),
    .rsp_valid    (rsp_valid),
    .rsp_tag      (rsp_tag),
    .rsp_data     (rsp_data),
    .wed_rsp_valid(wed_rsp_valid),
    .sum_rsp_valid(sum_rsp_valid),
    .rsp_local_tag(rsp_local_tag),
    .rsp_word     (rsp_word)
  );

endmodule

//--- tb/host_memory.sv
`include "afu_cfg.svh"

module host_memory (
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  input  logic [`AFU_ADDR_W-1:0] cmd_addr,
  input  logic [`AFU_TAG_W-1:0]  cmd_tag,
  output logic                   rsp_valid,
  output logic [`AFU_TAG_W-1:0]  rsp_tag,
  output logic [`AFU_DATA_W-1:0] rsp_data
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NTAGS = 1 << `AFU_TAG_W;

  logic [`AFU_DATA_W-1:0] mem [logic [`AFU_ADDR_W-1:0]];
  logic                   pend_valid [NTAGS];
  int                     pend_delay [NTAGS];
  logic [`AFU_DATA_W-1:0] pend_data [NTAGS];
  logic                   accept;
  logic [`AFU_ADDR_W-1:0] acc_addr;
  logic [`AFU_TAG_W-1:0]  acc_tag;
  int                     fire;

  // Unwritten words return a pattern built from every address bit.
  function automatic logic [`AFU_DATA_W-1:0] fill_word(input logic [`AFU_ADDR_W-1:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h5A5A_C3C3;
  endfunction

  function void write_word(input logic [`AFU_ADDR_W-1:0] addr,
                           input logic [`AFU_DATA_W-1:0] data);
    mem[addr] = data;
  endfunction

  function logic [`AFU_DATA_W-1:0] read_word(input logic [`AFU_ADDR_W-1:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return fill_word(addr);
  endfunction

  function void clear_pending();
    for (int t = 0; t < NTAGS; t++) begin
      pend_valid[t] = 1'b0;
      pend_delay[t] = 0;
    end
  endfunction

  initial begin
    cmd_ready = 1'b0;
    rsp_valid = 1'b0;
    rsp_tag   = '0;
    rsp_data  = '0;
    clear_pending();
    forever begin
      // Handshake is settled by mid-cycle.
      @(negedge clock);
      accept   = cmd_valid & cmd_ready;
      acc_addr = cmd_addr;
      acc_tag  = cmd_tag;
      @(posedge clock);
      #1;
      rsp_valid = 1'b0;
      if (rst) begin
        clear_pending();
        cmd_ready = 1'b0;
      end else begin
        // At most one response per cycle, lowest ready tag first.
        fire = -1;
        for (int t = 0; t < NTAGS; t++) begin
          if (pend_valid[t]) begin
            if (pend_delay[t] > 0) begin
              pend_delay[t]--;
            end
            if (pend_delay[t] == 0 && fire < 0) begin
              fire = t;
            end
          end
        end
        if (fire >= 0) begin
          rsp_valid        = 1'b1;
          rsp_tag          = `AFU_TAG_W'(fire);
          rsp_data         = pend_data[fire];
          pend_valid[fire] = 1'b0;
        end
        if (accept) begin
          pend_valid[acc_tag] = 1'b1;
          pend_delay[acc_tag] = int'($urandom_range(1, 8));
          pend_data[acc_tag]  = read_word(acc_addr);
        end
        cmd_ready = ($urandom_range(0, 3) != 0);
      end
    end
  end

endmodule

//--- tb/afu_tb.sv
`include "afu_cfg.svh"

module afu_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_JOBS       = 16;
  localparam int MAX_LATENCY    = 8;
  // Worst case per word, plus slack for the register traffic.
  localparam int TIMEOUT_CYCLES = NUM_JOBS * `AFU_MAX_LEN * MAX_LATENCY + 2000;

  logic                   clock;
  logic                   rst;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`AFU_ADDR_W-1:0] paddr;
  logic [`AFU_DATA_W-1:0] pwdata;
  logic [`AFU_DATA_W-1:0] prdata;
  logic                   pready;
  logic                   pslverr;
  logic                   cmd_valid;
  logic                   cmd_ready;
  logic [`AFU_ADDR_W-1:0] cmd_addr;
  logic [`AFU_TAG_W-1:0]  cmd_tag;
  logic                   rsp_valid;
  logic [`AFU_TAG_W-1:0]  rsp_tag;
  logic [`AFU_DATA_W-1:0] rsp_data;

  int    error_count;
  int    test_count;
  int    test_errors;
  int    job_index;
  int    cycles;
  string test_name;

  afu_top afu_top_inst (
    .clock    (clock),
    .rst      (rst),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .cmd_valid(cmd_valid),
    .cmd_ready(cmd_ready),
    .cmd_addr (cmd_addr),
    .cmd_tag  (cmd_tag),
    .rsp_valid(rsp_valid),
    .rsp_tag  (rsp_tag),
    .rsp_data (rsp_data)
  );

  host_memory host_memory_inst (
    .clock    (clock),
    .rst      (rst),
    .cmd_valid(cmd_valid),
    .cmd_ready(cmd_ready),
    .cmd_addr (cmd_addr),
    .cmd_tag  (cmd_tag),
    .rsp_valid(rsp_valid),
    .rsp_tag  (rsp_tag),
    .rsp_data (rsp_data)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clock);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s %s: expected %08h, actual %08h", test_name, what, expected, actual);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    test_count++;
    if (test_errors == 0) begin
      $display("PASS %s", test_name);
    end else begin
      $display("FAIL %s with %0d mismatches", test_name, test_errors);
    end
  endtask

  // One APB transfer: setup phase, then access phase sampled mid-cycle.
  task automatic apb_access(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic slverr);
    @(posedge clock);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clock);
    #1;
    penable = 1'b1;
    @(negedge clock);
    while (!pready) begin
      @(negedge clock);
    end
    rdata  = prdata;
    slverr = pslverr;
    @(posedge clock);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                           output logic slverr);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused, slverr);
  endtask

  task automatic apb_read(input logic [31:0] addr, output logic [31:0] data,
                          output logic slverr);
    apb_access(1'b0, addr, 32'h0, data, slverr);
  endtask

  // Descriptor and source block live in a fresh 64 KB window per job.
  task automatic place_job(input logic [31:0] len, input logic [1:0] src_off,
                           output logic [31:0] wed, output logic [31:0] src,
                           output logic [31:0] exp_sum);
    logic [31:0] word;
    wed = 32'h4000_0000 + job_index * 32'h0001_0000 + ($urandom_range(0, 63) << 2);
    src = wed + 32'h100 + ($urandom_range(0, 15) << 2) + {30'b0, src_off};
    job_index++;
    host_memory_inst.write_word(wed, src);
    host_memory_inst.write_word(wed + 32'd4, len);
    exp_sum = 32'h0;
    if (len <= `AFU_MAX_LEN) begin
      for (int i = 0; i < int'(len); i++) begin
        word = $urandom;
        host_memory_inst.write_word(src + 32'(i * 4), word);
        exp_sum = exp_sum + word;
      end
    end
  endtask

  task automatic wait_job_end(output logic [31:0] status);
    logic slverr;
    apb_read(`AFU_REG_STATUS, status, slverr);
    while (status != 32'(afu_pkg::DONE) && status != 32'(afu_pkg::ERROR)) begin
      apb_read(`AFU_REG_STATUS, status, slverr);
    end
  endtask

  task automatic run_job(input logic [31:0] len, input logic [1:0] src_off);
    logic [31:0] wed;
    logic [31:0] src;
    logic [31:0] exp_sum;
    logic [31:0] exp_err;
    logic [31:0] status;
    logic [31:0] result;
    logic [31:0] err;
    logic        slverr;
    place_job(len, src_off, wed, src, exp_sum);
    exp_err = 32'h0;
    if (len > `AFU_MAX_LEN) begin
      exp_err[afu_pkg::ERR_LEN] = 1'b1;
    end
    if (wed[1:0] != 2'b00 || src[1:0] != 2'b00) begin
      exp_err[afu_pkg::ERR_ALIGN] = 1'b1;
    end
    apb_write(`AFU_REG_WED, wed, slverr);
    apb_write(`AFU_REG_CTRL, 32'h1, slverr);
    wait_job_end(status);
    apb_read(`AFU_REG_RESULT, result, slverr);
    apb_read(`AFU_REG_ERR, err, slverr);
    if (exp_err != 32'h0) begin
      check("status", 32'(afu_pkg::ERROR), status);
    end else begin
      check("status", 32'(afu_pkg::DONE), status);
      check("result", exp_sum, result);
    end
    check("err", exp_err, err);
  endtask

  initial begin
    logic [31:0] data;
    logic [31:0] value;
    logic [31:0] wed;
    logic [31:0] src;
    logic [31:0] exp_sum;
    logic        slverr;

    void'($urandom(50612));
    rst         = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    error_count = 0;
    test_count  = 0;
    test_errors = 0;
    job_index   = 0;
    repeat (8) @(posedge clock);
    #1;
    rst = 1'b0;

    begin_test("register_access");
    value = $urandom;
    apb_write(`AFU_REG_WED, value, slverr);
    check("wed write pslverr", 32'h0, {31'b0, slverr});
    apb_read(`AFU_REG_WED, data, slverr);
    check("wed readback", value, data);
    check("wed read pslverr", 32'h0, {31'b0, slverr});
    apb_write(32'h14, 32'h1234_5678, slverr);
    check("unmapped write pslverr", 32'h1, {31'b0, slverr});
    apb_read(32'h20, data, slverr);
    check("unmapped read pslverr", 32'h1, {31'b0, slverr});
    end_test();

    begin_test("random_job");
    run_job(32'($urandom_range(1, `AFU_MAX_LEN)), 2'b00);
    end_test();

    begin_test("zero_length");
    run_job(32'h0, 2'b00);
    end_test();

    begin_test("length_too_long");
    run_job(32'(`AFU_MAX_LEN + $urandom_range(1, 1000)), 2'b00);
    end_test();

    begin_test("unaligned_source");
    run_job(32'($urandom_range(1, `AFU_MAX_LEN)), 2'($urandom_range(1, 3)));
    end_test();

    begin_test("back_to_back_jobs");
    for (int j = 0; j < 10; j++) begin
      run_job(32'($urandom_range(1, `AFU_MAX_LEN)), 2'b00);
    end
    end_test();

    // A full-length job leaves plenty of time in RUN for the abort.
    begin_test("abort_during_run");
    place_job(32'(`AFU_MAX_LEN), 2'b00, wed, src, exp_sum);
    apb_write(`AFU_REG_WED, wed, slverr);
    apb_write(`AFU_REG_CTRL, 32'h1, slverr);
    apb_read(`AFU_REG_STATUS, data, slverr);
    while (data == 32'(afu_pkg::IDLE) || data == 32'(afu_pkg::FETCH)) begin
      apb_read(`AFU_REG_STATUS, data, slverr);
    end
    check("status before abort", 32'(afu_pkg::RUN), data);
    apb_write(`AFU_REG_CTRL, 32'h2, slverr);
    apb_read(`AFU_REG_STATUS, data, slverr);
    check("status after abort", 32'(afu_pkg::IDLE), data);
    run_job(32'($urandom_range(1, `AFU_MAX_LEN)), 2'b00);
    end_test();

    $display("Summary: %0d tests run, %0d failed checks", test_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+include
verilog/afu_pkg.sv
verilog/mmio_regs.sv
verilog/job_control.sv
verilog/wed_fetch.sv
verilog/sum_engine.sv
verilog/cmd_arbiter.sv
verilog/afu_top.sv
tb/host_memory.sv
tb/afu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= afu_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) include/afu_cfg.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(BUILD_DIR)
